/* logic/softmax_pkg.sv */
`default_nettype none

package softmax_pkg;

  localparam int COEF_W      = 4;
  localparam int NODE_W      = 4;
  localparam int EXP_W       = 16;
  localparam int SUM_W       = 20;
  localparam int ALPHA_W     = 16;
  localparam int IN_DEPTH    = 8;
  localparam int E_DEPTH     = 16;
  localparam int SUM_DEPTH   = 4;
  localparam int OUT_CREDITS = 4;
  localparam int DIV_LAT     = 17;
  localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

  typedef logic [COEF_W-1:0]   coef_t;
  typedef logic [NODE_W-1:0]   node_cnt_t;
  typedef logic [EXP_W-1:0]    exp_t;
  typedef logic [SUM_W-1:0]    sum_t;
  typedef logic [ALPHA_W-1:0]  alpha_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  // one node of a subgraph
  typedef struct packed {
    node_cnt_t num_nodes;
    coef_t     coef;
  } sm_beat_t;

  // one record per finished subgraph
  typedef struct packed {
    node_cnt_t num_nodes;
    sum_t      sum;
  } sum_rec_t;

  typedef struct packed {
    exp_t dividend;
    sum_t divisor;
  } div_req_t;

endpackage

`default_nettype wire

/* logic/sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             wr,
  input  wire logic [width-1:0] din,
  input  wire logic             rd,
  output logic      [width-1:0] dout,
  output logic                  full,
  output logic                  empty
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] count_t;

  logic [width-1:0] mem [depth];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  count_t           count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  assign full  = (count == count_t'(depth));
  assign empty = (count == '0);
  // fall-through head
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/exp_sum_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module exp_sum_stage import softmax_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,

  input  wire sm_beat_t in_head,
  input  wire logic     in_empty,
  output logic          in_pop,

  input  wire logic     e_full,
  output logic          e_push,
  output exp_t          e_data,

  input  wire logic     sum_full,
  output logic          sum_push,
  output sum_rec_t      sum_data
);

  node_cnt_t node_cnt;
  sum_t      run_sum;
  exp_t      e_val;
  sum_t      sum_next;
  logic      last_beat;

  // power of two stands in for the exponential
  assign e_val = exp_t'(1) << in_head.coef;

  assign last_beat = (node_cnt == in_head.num_nodes - node_cnt_t'(1));

  // sum slot only needed on the closing beat
  assign in_pop = !in_empty && !e_full && (!last_beat || !sum_full);

  always_comb begin
    if (node_cnt == '0) begin
      sum_next = sum_t'(e_val);
    end else begin
      sum_next = run_sum + sum_t'(e_val);
    end
  end

  assign e_push = in_pop;
  assign e_data = e_val;

  assign sum_push           = in_pop && last_beat;
  assign sum_data.num_nodes = in_head.num_nodes;
  assign sum_data.sum       = sum_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_cnt <= '0;
    end else if (in_pop) begin
      if (last_beat) begin
        node_cnt <= '0;
      end else begin
        node_cnt <= node_cnt + 1'b1;
      end
    end
  end

  // running sum of the current subgraph
  always_ff @(posedge clk) begin
    if (in_pop) begin
      run_sum <= sum_next;
    end
  end

endmodule

`default_nettype wire

/* logic/norm_issue_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module norm_issue_stage import softmax_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,

  input  wire exp_t     e_head,
  input  wire logic     e_empty,
  output logic          e_pop,

  input  wire sum_rec_t sum_head,
  input  wire logic     sum_empty,
  output logic          sum_pop,

  input  wire logic     out_credit,
  output logic          div_valid,
  output div_req_t      div_req
);

  sum_rec_t  cur_rec;
  sum_rec_t  rec;
  node_cnt_t div_cnt;
  credit_t   credit_count;
  logic      first_node;
  logic      rec_ok;

  assign first_node = (div_cnt == '0);

  // node 0 takes the record straight off the sum FIFO head
  assign rec    = first_node ? sum_head : cur_rec;
  assign rec_ok = !first_node || !sum_empty;

  assign div_valid = !e_empty && rec_ok && (credit_count != '0);
  assign e_pop     = div_valid;
  assign sum_pop   = div_valid && first_node;

  assign div_req.dividend = e_head;
  assign div_req.divisor  = rec.sum;

  always_ff @(posedge clk) begin
    if (sum_pop) begin
      cur_rec <= sum_head;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (div_valid) begin
      if (div_cnt == rec.num_nodes - node_cnt_t'(1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // one credit spent per division and one back per pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= credit_t'(OUT_CREDITS);
    end else begin
      case ({div_valid, out_credit})
        2'b10:   credit_count <= credit_count - 1'b1;
        2'b01:   credit_count <= credit_count + 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/fxp_div_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module fxp_div_pipe import softmax_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     div_valid,
  input  wire div_req_t div_req,
  output logic          alpha_valid,
  output alpha_t        alpha
);

  // partial remainder one bit wider than the divisor
  logic [SUM_W:0]     rem_q [DIV_LAT-1];
  sum_t               dsr_q [DIV_LAT-1];
  logic [DIV_LAT-1:0] quo_q [DIV_LAT];
  logic               vld_q [DIV_LAT];

  for (genvar s = 0; s < DIV_LAT; s++) begin : g_stage
    logic [SUM_W:0]     rem_in;
    logic [SUM_W:0]     rem_sub;
    sum_t               dsr_in;
    logic [DIV_LAT-1:0] quo_in;
    logic               vld_in;
    logic               ge;

    if (s == 0) begin : g_first
      // e never exceeds sum so the quotient has no bits above bit 16
      // and the first remainder is e itself
      assign rem_in = {{(SUM_W+1-EXP_W){1'b0}}, div_req.dividend};
      assign dsr_in = div_req.divisor;
      assign quo_in = '0;
      assign vld_in = div_valid;
    end else begin : g_next
      // remaining dividend bits are all zero
      assign rem_in = {rem_q[s-1][SUM_W-1:0], 1'b0};
      assign dsr_in = dsr_q[s-1];
      assign quo_in = quo_q[s-1];
      assign vld_in = vld_q[s-1];
    end

    assign rem_sub = rem_in - {1'b0, dsr_in};
    assign ge      = (rem_in >= {1'b0, dsr_in});

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q[s] <= 1'b0;
      end else begin
        vld_q[s] <= vld_in;
      end
    end

    always_ff @(posedge clk) begin
      quo_q[s] <= {quo_in[DIV_LAT-2:0], ge};
    end

    // last stage needs only its quotient
    if (s < DIV_LAT - 1) begin : g_keep
      always_ff @(posedge clk) begin
        rem_q[s] <= ge ? rem_sub : rem_in;
        dsr_q[s] <= dsr_in;
      end
    end
  end

  assign alpha_valid = vld_q[DIV_LAT-1];

  // quotient of 2^16 only for a single-node subgraph
  always_comb begin
    if (quo_q[DIV_LAT-1][DIV_LAT-1]) begin
      alpha = '1;
    end else begin
      alpha = quo_q[DIV_LAT-1][ALPHA_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/softmax_top.sv */
`timescale 1ns/1ns
`default_nettype none

module softmax_top import softmax_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     in_valid,
  input  wire sm_beat_t in_beat,
  output logic          in_credit,
  input  wire logic     out_credit,
  output logic          alpha_valid,
  output alpha_t        alpha
);

  sm_beat_t in_head;
  logic     in_full;
  logic     in_empty;
  logic     in_pop;

  exp_t     e_din;
  exp_t     e_head;
  logic     e_push;
  logic     e_pop;
  logic     e_full;
  logic     e_empty;

  sum_rec_t sum_din;
  sum_rec_t sum_head;
  logic     sum_push;
  logic     sum_pop;
  logic     sum_full;
  logic     sum_empty;

  logic     div_valid;
  div_req_t div_req;

  sync_fifo #(.width($bits(sm_beat_t)), .depth(IN_DEPTH)) u_in_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (in_valid),
    .din   (in_beat),
    .rd    (in_pop),
    .dout  (in_head),
    .full  (in_full),
    .empty (in_empty)
  );

  sync_fifo #(.width(EXP_W), .depth(E_DEPTH)) u_e_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (e_push),
    .din   (e_din),
    .rd    (e_pop),
    .dout  (e_head),
    .full  (e_full),
    .empty (e_empty)
  );

  sync_fifo #(.width($bits(sum_rec_t)), .depth(SUM_DEPTH)) u_sum_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (sum_push),
    .din   (sum_din),
    .rd    (sum_pop),
    .dout  (sum_head),
    .full  (sum_full),
    .empty (sum_empty)
  );

  exp_sum_stage u_exp_sum (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_head  (in_head),
    .in_empty (in_empty),
    .in_pop   (in_pop),
    .e_full   (e_full),
    .e_push   (e_push),
    .e_data   (e_din),
    .sum_full (sum_full),
    .sum_push (sum_push),
    .sum_data (sum_din)
  );

  norm_issue_stage u_norm_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .e_head     (e_head),
    .e_empty    (e_empty),
    .e_pop      (e_pop),
    .sum_head   (sum_head),
    .sum_empty  (sum_empty),
    .sum_pop    (sum_pop),
    .out_credit (out_credit),
    .div_valid  (div_valid),
    .div_req    (div_req)
  );

  fxp_div_pipe u_div (
    .clk         (clk),
    .rst_n       (rst_n),
    .div_valid   (div_valid),
    .div_req     (div_req),
    .alpha_valid (alpha_valid),
    .alpha       (alpha)
  );

  // input credit goes back the cycle after a pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= in_pop;
    end
  end

endmodule

`default_nettype wire

/* testbench/softmax_props.sv */
`timescale 1ns/1ns
`default_nettype none

module softmax_props import softmax_pkg::*; (
  input wire logic    clk,
  input wire logic    rst_n,
  input wire logic    in_valid,
  input wire logic    in_full,
  input wire credit_t credit_count,
  input wire logic    div_valid,
  input wire logic    out_credit,
  input wire logic    alpha_valid
);

  // downstream credits in use, tracked from issues and returned pulses
  int spent;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spent <= 0;
    end else begin
      spent <= spent + int'(div_valid) - int'(out_credit);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(in_valid && in_full))
    else $error("input FIFO written while full");

  assert property (@(posedge clk) disable iff (!rst_n) credit_count <= credit_t'(OUT_CREDITS))
    else $error("output credit count above its initial value");

  assert property (@(posedge clk) disable iff (!rst_n) div_valid |-> spent < OUT_CREDITS)
    else $error("division issued without an output credit");

  // fixed divider latency
  assert property (@(posedge clk) disable iff (!rst_n) alpha_valid == $past(div_valid, DIV_LAT))
    else $error("alpha_valid does not follow div_valid by the divider latency");

endmodule

bind softmax_top softmax_props props_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .in_valid     (in_valid),
  .in_full      (in_full),
  .credit_count (u_norm_issue.credit_count),
  .div_valid    (div_valid),
  .out_credit   (out_credit),
  .alpha_valid  (alpha_valid)
);

`default_nettype wire

/* testbench/softmax_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module softmax_tb import softmax_pkg::*; ();

  localparam int NUM_SG          = 9;
  localparam int NUM_BEATS       = 44;
  localparam int WITHHOLD_CYCLES = 300;
  localparam int WATCHDOG_CYCLES = 200 * NUM_BEATS + 1000;

  // subgraph sizes and the coefficients of all nodes in input order
  localparam int SG_NODES [NUM_SG] = '{1, 4, 3, 5, 2, 1, 7, 6, 15};
  localparam int COEFS [NUM_BEATS] = '{
    3,
    2, 2, 2, 2,
    5, 5, 5,
    0, 1, 2, 3, 4,
    15, 0,
    15,
    7, 7, 7, 7, 7, 7, 7,
    1, 9, 3, 12, 0, 6,
    15, 15, 15, 15, 15, 15, 15, 15, 15, 15, 15, 15, 15, 15, 15
  };

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  sm_beat_t in_beat;
  logic     in_credit;
  logic     out_credit;
  logic     alpha_valid;
  alpha_t   alpha;

  int       beat_nodes [NUM_BEATS];
  alpha_t   exp_q [$];

  softmax_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .in_credit   (in_credit),
    .out_credit  (out_credit),
    .alpha_valid (alpha_valid),
    .alpha       (alpha)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // floor(e * 2^16 / sum) clipped below 2^16
  function automatic alpha_t expected_alpha(input int coef, input longint sum);
    longint q;
    q = (longint'(1) << (coef + ALPHA_W)) / sum;
    if (q >= (longint'(1) << ALPHA_W)) begin
      return '1;
    end
    return alpha_t'(q);
  endfunction

  initial begin
    int     idx;
    int     beat_idx;
    int     in_credits;
    int     alphas_rcvd;
    int     credits_seen;
    longint sum;
    alpha_t exp_alpha;
    logic   done;

    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;

    idx = 0;
    for (int s = 0; s < NUM_SG; s++) begin
      sum = 0;
      for (int n = 0; n < SG_NODES[s]; n++) begin
        sum += longint'(1) << COEFS[idx + n];
      end
      for (int n = 0; n < SG_NODES[s]; n++) begin
        beat_nodes[idx + n] = SG_NODES[s];
        exp_q.push_back(expected_alpha(COEFS[idx + n], sum));
      end
      idx += SG_NODES[s];
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // idle outputs before any beat
    repeat (5) begin
      @(posedge clk);
      assert (!in_credit && !alpha_valid)
        else abort_run("in_credit or alpha_valid went high with no input sent");
    end

    beat_idx     = 0;
    in_credits   = IN_DEPTH;
    alphas_rcvd  = 0;
    credits_seen = 0;
    done         = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (in_credit) begin
        in_credits++;
      end
      if (out_credit) begin
        credits_seen++;
      end
      if (alpha_valid) begin
        alphas_rcvd++;
        if (exp_q.size() == 0) begin
          abort_run("alpha_valid high with no result outstanding");
        end
        exp_alpha = exp_q.pop_front();
        assert (alpha == exp_alpha)
          else abort_run($sformatf("CHECK FAILED alpha got %h expected %h", alpha, exp_alpha));
        assert (alphas_rcvd <= OUT_CREDITS + credits_seen)
          else abort_run("more alphas arrived than downstream credits allow");
      end
      if (beat_idx < NUM_BEATS && in_credits > 0) begin
        in_valid          <= 1'b1;
        in_beat.num_nodes <= node_cnt_t'(beat_nodes[beat_idx]);
        in_beat.coef      <= coef_t'(COEFS[beat_idx]);
        in_credits--;
        beat_idx++;
      end else begin
        in_valid <= 1'b0;
      end
      done = (beat_idx == NUM_BEATS) && (exp_q.size() == 0) && (in_credits == IN_DEPTH);
    end

    // nothing extra may follow
    repeat (DIV_LAT + 4) begin
      @(posedge clk);
      assert (!alpha_valid && !in_credit)
        else abort_run("output or credit pulse after all results were received");
    end

    $display("Simulation passed");
    $finish;
  end

  // downstream returns one credit per received alpha after random gaps
  initial begin : credit_return
    int          owed;
    int          gap;
    logic [31:0] rng;

    owed       = 0;
    gap        = WITHHOLD_CYCLES;
    rng        = 32'h293b;
    out_credit = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      if (alpha_valid) begin
        owed++;
      end
      if (gap > 0) begin
        gap--;
        out_credit <= 1'b0;
      end else if (owed > 0) begin
        out_credit <= 1'b1;
        owed--;
        rng = lcg_next(rng);
        gap = int'(rng[20:18]);
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("timeout: not all results and input credits came back in time");
  end

endmodule

`default_nettype wire

/* build.f */
logic/softmax_pkg.sv
logic/sync_fifo.sv
logic/exp_sum_stage.sv
logic/norm_issue_stage.sv
logic/fxp_div_pipe.sv
logic/softmax_top.sv
testbench/softmax_props.sv
testbench/softmax_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' build.f)

all: run

obj_dir/Vsoftmax_tb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module softmax_tb

run: obj_dir/Vsoftmax_tb
	./obj_dir/Vsoftmax_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
